// File: common/exu_params.svh
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// Data path width of the execute unit
`define EXU_XLEN 32

// Architectural integer registers, x0 included
`define EXU_NREGS 32

`endif

// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

  // Major opcodes that the execute unit accepts
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // Funct3 values of OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Funct3 values of BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Bit 5 of funct7 picks SUB and SRA over ADD and SRL
  localparam int unsigned F7_ALT_BIT = 5;

  // Field layout shared by R, I and B formats
  // For I and B the upper fields carry immediate bits instead
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } instr_t;

endpackage

// File: common/exu_pkg.sv
`include "exu_params.svh"

package exu_pkg;

  localparam int unsigned REG_AW = $clog2(`EXU_NREGS);

  // Operation set of the ALU
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLT,
    SLTU,
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    SLL,
    SRL,
    SRA,
    AND,
    OR,
    XOR
  } alu_op_e;

  // One instruction after decode
  typedef struct packed {
    alu_op_e               op;
    logic [REG_AW-1:0]     rs1;
    logic [REG_AW-1:0]     rs2;
    logic [REG_AW-1:0]     rd;
    logic [`EXU_XLEN-1:0]  imm;
    logic                  use_imm;
    logic                  we;
    logic                  is_branch;
  } dec_t;

  // What leaves on the result port
  typedef struct packed {
    logic [REG_AW-1:0]     rd;
    logic [`EXU_XLEN-1:0]  value;
    logic                  is_branch;
    logic                  taken;
  } res_t;

endpackage

// File: exu/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [31:0]      alu_a,
  input  logic [31:0]      alu_b,
  input  exu_pkg::alu_op_e alu_op,
  output logic [31:0]      alu_c
);

  logic        sub_mode;
  logic [32:0] add_a;
  logic [32:0] add_b_raw;
  logic [32:0] add_b;
  logic [33:0] add_sum;
  logic [31:0] add_res;
  logic        ovf;
  logic        lt_signed;
  logic        lt_unsigned;
  logic        is_zero;
  logic [4:0]  shamt;
  logic [31:0] shift_in;
  logic [32:0] shift_ext;
  logic [32:0] shift_out;
  logic [31:0] logic_res;

  // Every compare is a subtraction on the same adder
  always_comb begin
    case (alu_op)
      exu_pkg::SUB, exu_pkg::SLT, exu_pkg::SLTU,
      exu_pkg::BEQ, exu_pkg::BNE, exu_pkg::BLT,
      exu_pkg::BGE, exu_pkg::BLTU, exu_pkg::BGEU: sub_mode = 1'b1;
      default: sub_mode = 1'b0;
    endcase
  end

  // The extra low bit turns the inverted operand into two's complement
  assign add_a     = {alu_a, 1'b1};
  assign add_b_raw = {alu_b, 1'b0};
  assign add_b     = sub_mode ? ~add_b_raw : add_b_raw;
  assign add_sum   = {1'b0, add_a} + {1'b0, add_b};
  assign add_res   = add_sum[32:1];

  // Sign of a-b is wrong exactly when the subtraction overflows
  assign ovf         = (alu_a[31] != alu_b[31]) && (add_res[31] != alu_a[31]);
  assign lt_signed   = add_res[31] ^ ovf;
  assign lt_unsigned = ~add_sum[33];
  assign is_zero     = ~|add_res;

  // Left shifts go through the right shifter on reversed bits
  always_comb begin
    shift_in = alu_a;
    if (alu_op == exu_pkg::SLL) begin
      for (int i = 0; i < 32; i++) begin
        shift_in[i] = alu_a[31-i];
      end
    end
  end

  assign shamt     = alu_b[4:0];
  assign shift_ext = {(alu_op == exu_pkg::SRA) & shift_in[31], shift_in};
  assign shift_out = $signed(shift_ext) >>> shamt;

  always_comb begin
    case (alu_op)
      exu_pkg::OR:  logic_res = alu_a | alu_b;
      exu_pkg::XOR: logic_res = alu_a ^ alu_b;
      default:      logic_res = alu_a & alu_b;
    endcase
  end

  always_comb begin
    alu_c = add_res;
    case (alu_op)
      exu_pkg::BEQ:  alu_c = {31'b0, is_zero};
      exu_pkg::BNE:  alu_c = {31'b0, ~is_zero};
      exu_pkg::SLT, exu_pkg::BLT:   alu_c = {31'b0, lt_signed};
      exu_pkg::SLTU, exu_pkg::BLTU: alu_c = {31'b0, lt_unsigned};
      exu_pkg::BGE:  alu_c = {31'b0, ~lt_signed};
      exu_pkg::BGEU: alu_c = {31'b0, ~lt_unsigned};
      exu_pkg::SLL: begin
        for (int i = 0; i < 32; i++) begin
          alu_c[i] = shift_out[31-i];
        end
      end
      exu_pkg::SRL, exu_pkg::SRA: alu_c = shift_out[31:0];
      exu_pkg::AND, exu_pkg::OR, exu_pkg::XOR: alu_c = logic_res;
      default: ;
    endcase
  end

endmodule

// File: exu/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder (
  input  logic [31:0]   instr,
  output exu_pkg::dec_t dec
);

  rv_isa_pkg::instr_t fields;
  logic [31:0]        imm_i;
  logic [31:0]        imm_b;
  logic               alt;
  logic               rd_nonzero;

  assign fields     = rv_isa_pkg::instr_t'(instr);
  assign alt        = fields.funct7[rv_isa_pkg::F7_ALT_BIT];
  assign rd_nonzero = (fields.rd != '0);

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  function automatic exu_pkg::alu_op_e arith_op(input logic [2:0] funct3,
                                                input logic       sel_alt);
    exu_pkg::alu_op_e op;
    case (funct3)
      rv_isa_pkg::F3_ADD_SUB: op = sel_alt ? exu_pkg::SUB : exu_pkg::ADD;
      rv_isa_pkg::F3_SLL:     op = exu_pkg::SLL;
      rv_isa_pkg::F3_SLT:     op = exu_pkg::SLT;
      rv_isa_pkg::F3_SLTU:    op = exu_pkg::SLTU;
      rv_isa_pkg::F3_XOR:     op = exu_pkg::XOR;
      rv_isa_pkg::F3_SRL_SRA: op = sel_alt ? exu_pkg::SRA : exu_pkg::SRL;
      rv_isa_pkg::F3_OR:      op = exu_pkg::OR;
      rv_isa_pkg::F3_AND:     op = exu_pkg::AND;
      default:                op = exu_pkg::ADD;
    endcase
    return op;
  endfunction

  always_comb begin
    dec     = '0;
    dec.op  = exu_pkg::ADD;
    dec.rs1 = fields.rs1;
    dec.rs2 = fields.rs2;
    dec.imm = imm_i;
    case (fields.opcode)
      rv_isa_pkg::OPC_OP: begin
        dec.op = arith_op(fields.funct3, alt);
        dec.rd = fields.rd;
        dec.we = rd_nonzero;
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        // Funct7 bit 5 only selects SRAI here because OP_IMM has no SUB
        dec.op      = arith_op(fields.funct3,
                               alt && (fields.funct3 == rv_isa_pkg::F3_SRL_SRA));
        dec.rd      = fields.rd;
        dec.use_imm = 1'b1;
        dec.we      = rd_nonzero;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
        case (fields.funct3)
          rv_isa_pkg::F3_BEQ:  dec.op = exu_pkg::BEQ;
          rv_isa_pkg::F3_BNE:  dec.op = exu_pkg::BNE;
          rv_isa_pkg::F3_BLT:  dec.op = exu_pkg::BLT;
          rv_isa_pkg::F3_BGE:  dec.op = exu_pkg::BGE;
          rv_isa_pkg::F3_BLTU: dec.op = exu_pkg::BLTU;
          rv_isa_pkg::F3_BGEU: dec.op = exu_pkg::BGEU;
          // Reserved branch encodings retire as no-ops
          default: dec.is_branch = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// File: exu/regfile.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [$clog2(`EXU_NREGS)-1:0] raddr1,
  input  logic [$clog2(`EXU_NREGS)-1:0] raddr2,
  output logic [`EXU_XLEN-1:0]          rdata1,
  output logic [`EXU_XLEN-1:0]          rdata2,
  input  logic                          we,
  input  logic [$clog2(`EXU_NREGS)-1:0] waddr,
  input  logic [`EXU_XLEN-1:0]          wdata
);

  logic [`EXU_XLEN-1:0] regs [`EXU_NREGS];

  // x0 reads zero whatever the array holds
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `EXU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// File: hw/exu_ctrl.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_req,
  input  logic [31:0]          in_instr,
  output logic                 in_ack,
  output logic                 out_req,
  output exu_pkg::res_t        out_res,
  input  logic                 out_ack,
  output logic [31:0]          dec_instr,
  input  exu_pkg::dec_t        dec,
  input  logic [`EXU_XLEN-1:0] rdata1,
  input  logic [`EXU_XLEN-1:0] rdata2,
  output logic [`EXU_XLEN-1:0] alu_a,
  output logic [`EXU_XLEN-1:0] alu_b,
  output exu_pkg::alu_op_e     alu_op,
  input  logic [`EXU_XLEN-1:0] alu_c,
  output logic                 we,
  output logic [4:0]           waddr,
  output logic [`EXU_XLEN-1:0] wdata
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    HOLD,
    DRAIN
  } state_e;

  state_e      state;
  logic [31:0] instr_q;

  assign dec_instr = instr_q;
  assign alu_a     = rdata1;
  assign alu_b     = dec.use_imm ? dec.imm : rdata2;
  assign alu_op    = dec.op;

  // Write back happens on the same edge that registers the result
  assign we    = (state == EXEC) && dec.we;
  assign waddr = dec.rd;
  assign wdata = alu_c;

  always_ff @(posedge clk) begin
    if ((state == IDLE) && in_req) begin
      instr_q <= in_instr;
    end
    if (state == EXEC) begin
      out_res.rd        <= dec.rd;
      out_res.value     <= alu_c;
      out_res.is_branch <= dec.is_branch;
      out_res.taken     <= dec.is_branch & alu_c[0];
    end
  end

  // Both four-phase ports rise together, then each returns to zero on its own
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      in_ack  <= 1'b0;
      out_req <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (in_req) state <= EXEC;
        end
        EXEC: begin
          in_ack  <= 1'b1;
          out_req <= 1'b1;
          state   <= HOLD;
        end
        HOLD: begin
          if (!in_req) in_ack <= 1'b0;
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= DRAIN;
          end
        end
        DRAIN: begin
          if (!in_req) in_ack <= 1'b0;
          // Wait for the consumer to release out_ack and the producer to finish
          if (!out_ack && !in_ack) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: hw/exu_top.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_top (
  input  logic          clk,
  input  logic          rst,
  input  logic          in_req,
  input  logic [31:0]   in_instr,
  output logic          in_ack,
  output logic          out_req,
  output exu_pkg::res_t out_res,
  input  logic          out_ack
);

  logic [31:0]          dec_instr;
  exu_pkg::dec_t        dec;
  logic [`EXU_XLEN-1:0] rdata1;
  logic [`EXU_XLEN-1:0] rdata2;
  logic [`EXU_XLEN-1:0] alu_a;
  logic [`EXU_XLEN-1:0] alu_b;
  logic [`EXU_XLEN-1:0] alu_c;
  exu_pkg::alu_op_e     alu_op;
  logic                 we;
  logic [4:0]           waddr;
  logic [`EXU_XLEN-1:0] wdata;

  exu_ctrl u_exu_ctrl (
    .clk       (clk),
    .rst       (rst),
    .in_req    (in_req),
    .in_instr  (in_instr),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .out_res   (out_res),
    .out_ack   (out_ack),
    .dec_instr (dec_instr),
    .dec       (dec),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_op    (alu_op),
    .alu_c     (alu_c),
    .we        (we),
    .waddr     (waddr),
    .wdata     (wdata)
  );

  alu_decoder u_alu_decoder (
    .instr (dec_instr),
    .dec   (dec)
  );

  regfile u_regfile (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (dec.rs1),
    .raddr2 (dec.rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .we     (we),
    .waddr  (waddr),
    .wdata  (wdata)
  );

  alu u_alu (
    .alu_a  (alu_a),
    .alu_b  (alu_b),
    .alu_op (alu_op),
    .alu_c  (alu_c)
  );

endmodule

// File: dv/exu_checker.sv
`timescale 1ns/1ps

module exu_checker (
  input logic          clk,
  input logic          rst,
  input logic          in_req,
  input logic          in_ack,
  input logic          out_req,
  input exu_pkg::res_t out_res,
  input logic          out_ack
);

  // Both ports come out of reset idle
  reset_idle: assert property (@(posedge clk) rst |=> (!in_ack && !out_req))
    else $error("in_ack or out_req is high after reset");

  // A result stays offered until the consumer takes it
  req_held: assert property (@(posedge clk) disable iff (rst)
    (out_req && !out_ack) |=> out_req)
    else $error("out_req dropped before out_ack");

  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(in_ack) |-> in_req)
    else $error("in_ack rose while in_req was low");

  // The result register only loads while the output port is idle
  res_stable: assert property (@(posedge clk) disable iff (rst)
    (out_req && $past(out_req)) |-> $stable(out_res))
    else $error("out_res changed while out_req was high");

  rise_together: assert property (@(posedge clk) disable iff (rst)
    $rose(out_req) |-> $rose(in_ack))
    else $error("out_req rose without in_ack in the same cycle");

  req_released: assert property (@(posedge clk) disable iff (rst)
    $fell(out_req) |-> $past(out_ack))
    else $error("out_req fell although out_ack was low");

endmodule

// File: dv/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

  localparam int NTESTS    = 4;
  localparam int NINSTR    = 40;
  localparam int MAX_DELAY = 4;
  localparam int LIMIT     = NTESTS * NINSTR * (6 + MAX_DELAY) + 200;

  logic          clk;
  logic          rst      = 1'b1;
  logic          in_req   = 1'b0;
  logic [31:0]   in_instr = '0;
  logic          in_ack;
  logic          out_req;
  exu_pkg::res_t out_res;
  logic          out_ack  = 1'b0;

  logic [31:0] shadow [32];
  logic [31:0] rng = 32'h11fdefcf;
  logic [31:0] corner [$];
  logic [31:0] prog [$];
  int          errors = 0;
  int          cycles = 0;

  exu_top u_exu_top (
    .clk      (clk),
    .rst      (rst),
    .in_req   (in_req),
    .in_instr (in_instr),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_res  (out_res),
    .out_ack  (out_ack)
  );

  bind exu_top exu_checker u_exu_checker (
    .clk     (clk),
    .rst     (rst),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_res (out_res),
    .out_ack (out_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: the handshake stalled, run stopped after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // Registers x0..x15 so that corner results get read back
  function automatic logic [31:0] rand_instr();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] bf3;
    rng = xorshift(rng);
    rd  = {1'b0, rng[3:0]};
    rs1 = {1'b0, rng[7:4]};
    rs2 = {1'b0, rng[11:8]};
    bf3 = (rng[14:13] == 2'b01) ? {2'b11, rng[12]} : rng[14:12];
    case (rng[16:15])
      2'b00: return r_type({1'b0, rng[17], 5'b0}, rs2, rs1, rng[14:12], rd);
      2'b01: return b_type(rng[30:18], rs2, rs1, bf3);
      default: return i_type(rng[29:18], rs1, rng[14:12], rd);
    endcase
  endfunction

  // RV32I result of one instruction on the shadow registers
  function automatic void model(input logic [31:0] ins, output logic [31:0] val,
                                output logic tkn);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    a   = shadow[ins[19:15]];
    b   = (ins[6:0] == 7'b0010011) ? {{20{ins[31]}}, ins[31:20]} : shadow[ins[24:20]];
    sh  = b[4:0];
    tkn = 1'b0;
    if (ins[6:0] == 7'b1100011) begin
      case (ins[14:12])
        3'd0: tkn = (a == b);
        3'd1: tkn = (a != b);
        3'd4: tkn = ($signed(a) < $signed(b));
        3'd5: tkn = ($signed(a) >= $signed(b));
        3'd6: tkn = (a < b);
        default: tkn = (a >= b);
      endcase
      val = {31'b0, tkn};
    end else begin
      case (ins[14:12])
        3'd0: val = (ins[30] && ins[6:0] == 7'b0110011) ? a - b : a + b;
        3'd1: val = a << sh;
        3'd2: val = {31'b0, $signed(a) < $signed(b)};
        3'd3: val = {31'b0, a < b};
        3'd4: val = a ^ b;
        3'd5: begin
          if (ins[30]) begin
            val = $signed(a) >>> sh;
          end else begin
            val = a >> sh;
          end
        end
        3'd6: val = a | b;
        default: val = a & b;
      endcase
    end
  endfunction

  // Runs prog[k] through both ports and offers prog[k+1] as soon as in_ack drops
  task automatic issue(input int k);
    logic [31:0] ins;
    logic [31:0] exp_val;
    logic        exp_tkn;
    logic        exp_br;
    int          delay;
    ins    = prog[k];
    exp_br = (ins[6:0] == 7'b1100011);
    model(ins, exp_val, exp_tkn);
    rng   = xorshift(rng);
    delay = int'(rng % (MAX_DELAY + 1));
    in_instr <= ins;
    in_req   <= 1'b1;
    do @(posedge clk); while (!out_req);
    assert (out_res.value == exp_val && out_res.taken == exp_tkn &&
            out_res.is_branch == exp_br && (exp_br || out_res.rd == ins[11:7]))
      else begin
        errors++;
        $display("mismatch at %0t: instr %h gave value %h taken %b, expected %h taken %b",
                 $time, ins, out_res.value, out_res.taken, exp_val, exp_tkn);
      end
    if (!exp_br && ins[11:7] != 5'd0) shadow[ins[11:7]] = exp_val;
    in_req <= 1'b0;
    fork
      begin
        // The next request may arrive while the result is still held
        do @(posedge clk); while (in_ack);
        if (k + 1 < prog.size()) begin
          in_instr <= prog[k + 1];
          in_req   <= 1'b1;
        end
      end
      begin
        // Hold off the consumer to exercise back-pressure
        repeat (delay) @(posedge clk);
        out_ack <= 1'b1;
        do @(posedge clk); while (out_req);
        out_ack <= 1'b0;
      end
    join
  endtask

  initial begin
    int first;
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    // x1 = 32'h80000000 and x2 = 32'h7fffffff, then operations across the sign boundary
    // The last branch names x1 in its rd bits, and the final add reads x1 back
    corner = '{
      i_type(12'd1, 5'd0, 3'd0, 5'd1), i_type(12'd31, 5'd1, 3'd1, 5'd1),
      i_type(12'hfff, 5'd0, 3'd0, 5'd2), i_type(12'd1, 5'd2, 3'd5, 5'd2),
      r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd4),
      r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd5), r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd6),
      r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd7), r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd8),
      r_type(7'h00, 5'd2, 5'd1, 3'd5, 5'd9), r_type(7'h00, 5'd2, 5'd4, 3'd1, 5'd10),
      r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd11), r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd12),
      r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd13), i_type(12'hfff, 5'd1, 3'd2, 5'd14),
      i_type(12'hfff, 5'd2, 3'd3, 5'd15), i_type(12'h404, 5'd1, 3'd5, 5'd8),
      b_type(13'd16, 5'd2, 5'd1, 3'd0), b_type(13'd16, 5'd2, 5'd1, 3'd1),
      b_type(13'd16, 5'd2, 5'd1, 3'd4), b_type(13'd16, 5'd2, 5'd1, 3'd5),
      b_type(13'd16, 5'd2, 5'd1, 3'd6), b_type(13'd16, 5'd2, 5'd1, 3'd7),
      b_type(13'h1800, 5'd1, 5'd1, 3'd0), i_type(12'd5, 5'd1, 3'd0, 5'd0),
      r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd9), r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd10)
    };
    prog = corner;
    for (int n = 0; n < (NTESTS - 1) * NINSTR; n++) prog.push_back(rand_instr());
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    first = errors;
    foreach (corner[i]) issue(i);
    $display("test 0 corner operands: %0d instructions, %0d mismatches",
             corner.size(), errors - first);
    for (int t = 1; t < NTESTS; t++) begin
      first = errors;
      for (int n = 0; n < NINSTR; n++) issue(corner.size() + (t - 1) * NINSTR + n);
      $display("test %0d random mix: %0d instructions, %0d mismatches",
               t, NINSTR, errors - first);
    end
    $display("%0d tests run, %0d mismatches in total", NTESTS, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+common
common/rv_isa_pkg.sv
common/exu_pkg.sv
exu/alu.sv
exu/alu_decoder.sv
exu/regfile.sv
hw/exu_ctrl.sv
hw/exu_top.sv
dv/exu_checker.sv
dv/exu_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build exu_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module exu_tb -Mdir obj_dir
	./obj_dir/Vexu_tb | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || \
		(echo "FAIL: pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
